// File: control_unit.f
source/control_pkg.sv
source/main_decoder.sv
source/alu_decoder.sv
source/ex_control_stage.sv
source/control_unit.sv
dv/control_unit_assertions.sv
dv/control_unit_tb.sv

// File: dv/control_unit_assertions.sv
module control_unit_assertions (
    input logic                         clk,
    input logic                         rst,
    input logic                         zero,
    input logic                         conditional,
    input logic                         reg_write,
    input logic                         mem_write,
    input logic                         alu_src,
    input logic                         jump,
    input control_pkg::result_src_e     result_src,
    input control_pkg::imm_src_e        imm_src,
    input control_pkg::store_size_e     ctrl_data_mem,
    input control_pkg::load_ext_e       ctrl_sign_ext_data,
    input control_pkg::branch_cond_e    branch_cond,
    input control_pkg::alu_op_e         alu_control,
    input logic                         pc_src
);

    logic pc_rule;
    logic inactive;

    // count of failed assertions for the closing report
    int   fail_count = 0;

    // next-pc select from branch kind and live flags
    assign pc_rule = jump
        || (branch_cond == control_pkg::BR_EQ && zero)
        || (branch_cond == control_pkg::BR_NE && !zero)
        || (branch_cond == control_pkg::BR_LT && conditional)
        || (branch_cond == control_pkg::BR_GE && !conditional);

    // all-zero control word
    assign inactive = !reg_write && !mem_write && !alu_src && !jump && !pc_src
        && result_src == control_pkg::RES_ALU && imm_src == control_pkg::IMM_I
        && ctrl_data_mem == control_pkg::ST_WORD
        && ctrl_sign_ext_data == control_pkg::LD_WORD
        && branch_cond == control_pkg::BR_NONE && alu_control == control_pkg::ALU_ADD;

    // no instruction both stores and writes rd
    no_store_and_write: assert property (@(posedge clk) disable iff (rst)
        !(mem_write && reg_write))
        else
        begin
            $error("mem_write and reg_write are both high");
            fail_count++;
        end

    reset_clears: assert property (@(posedge clk) rst |=> inactive)
        else
        begin
            $error("controls not inactive one cycle after reset");
            fail_count++;
        end

    // store width only meaningful on a store
    width_needs_store: assert property (@(posedge clk) disable iff (rst)
        (ctrl_data_mem != control_pkg::ST_WORD) |-> mem_write)
        else
        begin
            $error("store width set without mem_write");
            fail_count++;
        end

    pc_select_rule: assert property (@(posedge clk) disable iff (rst)
        pc_src == pc_rule)
        else
        begin
            $error("pc_src does not match branch kind, jump and flags");
            fail_count++;
        end

endmodule

bind ex_control_stage control_unit_assertions u_control_unit_assertions (.*);

// File: dv/control_unit_input.txt
// op f3 f7 zero cond, then expected pc_src result_src mem_write alu_control
// alu_src imm_src reg_write ctrl_data_mem ctrl_sign_ext_data, all hex
// loads lb lh lw lbu lhu, then illegal funct3
03 0 00 0 0 0 1 0 0 1 0 1 0 2
03 1 00 0 0 0 1 0 0 1 0 1 0 1
03 2 00 0 0 0 1 0 0 1 0 1 0 0
03 4 00 0 0 0 1 0 0 1 0 1 0 3
03 5 00 0 0 0 1 0 0 1 0 1 0 4
03 3 00 0 0 0 0 0 0 0 0 0 0 0
// stores sb sh sw, then illegal funct3
23 0 00 0 0 0 0 1 0 1 1 0 2 0
23 1 00 0 0 0 0 1 0 1 1 0 1 0
23 2 00 0 0 0 0 1 0 1 1 0 0 0
23 3 00 0 0 0 0 0 0 0 0 0 0 0
// immediate alu ops, addi with funct7 bit 5 set still adds
13 0 20 0 0 0 0 0 0 1 0 1 0 0
13 1 00 0 0 0 0 0 5 1 0 1 0 0
13 2 00 0 0 0 0 0 8 1 0 1 0 0
13 3 00 0 0 0 0 0 9 1 0 1 0 0
13 4 00 0 0 0 0 0 4 1 0 1 0 0
13 5 00 0 0 0 0 0 6 1 0 1 0 0
13 5 20 0 0 0 0 0 7 1 0 1 0 0
13 6 00 0 0 0 0 0 2 1 0 1 0 0
13 7 00 0 0 0 0 0 3 1 0 1 0 0
// register alu ops
33 0 00 0 0 0 0 0 0 0 0 1 0 0
33 0 20 0 0 0 0 0 1 0 0 1 0 0
33 1 00 0 0 0 0 0 5 0 0 1 0 0
33 2 00 0 0 0 0 0 8 0 0 1 0 0
33 3 00 0 0 0 0 0 9 0 0 1 0 0
33 4 00 0 0 0 0 0 4 0 0 1 0 0
33 5 00 0 0 0 0 0 6 0 0 1 0 0
33 5 20 0 0 0 0 0 7 0 0 1 0 0
33 6 00 0 0 0 0 0 2 0 0 1 0 0
33 7 00 0 0 0 0 0 3 0 0 1 0 0
// branches beq bne blt bge bltu bgeu over all zero/cond pairs
63 0 00 0 0 0 0 0 1 0 2 0 0 0
63 0 00 0 1 0 0 0 1 0 2 0 0 0
63 0 00 1 0 1 0 0 1 0 2 0 0 0
63 0 00 1 1 1 0 0 1 0 2 0 0 0
63 1 00 0 0 1 0 0 1 0 2 0 0 0
63 1 00 0 1 1 0 0 1 0 2 0 0 0
63 1 00 1 0 0 0 0 1 0 2 0 0 0
63 1 00 1 1 0 0 0 1 0 2 0 0 0
63 4 00 0 0 0 0 0 8 0 2 0 0 0
63 4 00 0 1 1 0 0 8 0 2 0 0 0
63 4 00 1 0 0 0 0 8 0 2 0 0 0
63 4 00 1 1 1 0 0 8 0 2 0 0 0
63 5 00 0 0 1 0 0 8 0 2 0 0 0
63 5 00 0 1 0 0 0 8 0 2 0 0 0
63 5 00 1 0 1 0 0 8 0 2 0 0 0
63 5 00 1 1 0 0 0 8 0 2 0 0 0
63 6 00 0 0 0 0 0 9 0 2 0 0 0
63 6 00 0 1 1 0 0 9 0 2 0 0 0
63 6 00 1 0 0 0 0 9 0 2 0 0 0
63 6 00 1 1 1 0 0 9 0 2 0 0 0
63 7 00 0 0 1 0 0 9 0 2 0 0 0
63 7 00 0 1 0 0 0 9 0 2 0 0 0
63 7 00 1 0 1 0 0 9 0 2 0 0 0
63 7 00 1 1 0 0 0 9 0 2 0 0 0
63 2 00 1 1 0 0 0 0 0 0 0 0 0
// jal jalr lui auipc
6f 0 00 1 0 1 2 0 0 0 3 1 0 0
67 0 00 0 1 1 2 0 0 0 0 1 0 0
37 0 00 1 1 0 3 0 0 0 4 1 0 0
17 0 00 0 0 0 4 0 0 1 4 1 0 0
// undefined opcodes
00 0 00 0 0 0 0 0 0 0 0 0 0 0
7f 7 7f 1 1 0 0 0 0 0 0 0 0 0
0f 0 00 1 0 0 0 0 0 0 0 0 0 0

// File: dv/control_unit_tb.sv
module control_unit_tb;

    logic                           clk;
    logic                           rst;
    control_pkg::opcode_e           op;
    logic [control_pkg::F3_W-1:0]   funct3;
    logic [control_pkg::F7_W-1:0]   funct7;
    logic                           zero;
    logic                           conditional;
    logic                           pc_src;
    control_pkg::result_src_e       result_src;
    logic                           mem_write;
    control_pkg::alu_op_e           alu_control;
    logic                           alu_src;
    control_pkg::imm_src_e          imm_src;
    logic                           reg_write;
    control_pkg::store_size_e       ctrl_data_mem;
    control_pkg::load_ext_e         ctrl_sign_ext_data;

    // one row per vector in data file column order
    logic [7:0] tbl [0:255][0:13];
    int         n_vec;
    int         vec_idx;
    int         checks;
    int         errors;
    int         assert_fails;
    int         cycles;
    int         max_cycles;
    string      ctx;

    control_unit DUT (
        .clk                (clk),
        .rst                (rst),
        .op                 (op),
        .funct3             (funct3),
        .funct7             (funct7),
        .zero               (zero),
        .conditional        (conditional),
        .pc_src             (pc_src),
        .result_src         (result_src),
        .mem_write          (mem_write),
        .alu_control        (alu_control),
        .alu_src            (alu_src),
        .imm_src            (imm_src),
        .reg_write          (reg_write),
        .ctrl_data_mem      (ctrl_data_mem),
        .ctrl_sign_ext_data (ctrl_sign_ext_data)
    );

    always #2 clk = ~clk;

    // watchdog with its limit set once the vectors are loaded
    always @(posedge clk)
    begin
        cycles++;
        if (max_cycles > 0 && cycles >= max_cycles)
        begin
            $display("timeout: the run did not finish within %0d cycles", max_cycles);
            $display("checks: %0d, errors: %0d", checks, errors);
            $display("Verification failed");
            $finish;
        end
    end

    task automatic check_bit(input string name, input logic exp, input logic act);
        checks++;
        if (act !== exp)
        begin
            errors++;
            $display("FAILED %s (%s): expected %h, actual %h", name, ctx, exp, act);
        end
    endtask

    task automatic check_alu(input string name, input control_pkg::alu_op_e exp,
                             input control_pkg::alu_op_e act);
        checks++;
        if (act !== exp)
        begin
            errors++;
            $display("FAILED %s (%s): expected %h, actual %h", name, ctx, exp, act);
        end
    endtask

    task automatic check_result(input string name, input control_pkg::result_src_e exp,
                                input control_pkg::result_src_e act);
        checks++;
        if (act !== exp)
        begin
            errors++;
            $display("FAILED %s (%s): expected %h, actual %h", name, ctx, exp, act);
        end
    endtask

    task automatic check_imm(input string name, input control_pkg::imm_src_e exp,
                             input control_pkg::imm_src_e act);
        checks++;
        if (act !== exp)
        begin
            errors++;
            $display("FAILED %s (%s): expected %h, actual %h", name, ctx, exp, act);
        end
    endtask

    task automatic check_store(input string name, input control_pkg::store_size_e exp,
                               input control_pkg::store_size_e act);
        checks++;
        if (act !== exp)
        begin
            errors++;
            $display("FAILED %s (%s): expected %h, actual %h", name, ctx, exp, act);
        end
    endtask

    task automatic check_load(input string name, input control_pkg::load_ext_e exp,
                              input control_pkg::load_ext_e act);
        checks++;
        if (act !== exp)
        begin
            errors++;
            $display("FAILED %s (%s): expected %h, actual %h", name, ctx, exp, act);
        end
    endtask

    // inactive word expected in and right after reset
    task automatic check_inactive();
        check_bit("pc_src", 1'b0, pc_src);
        check_result("result_src", control_pkg::RES_ALU, result_src);
        check_bit("mem_write", 1'b0, mem_write);
        check_alu("alu_control", control_pkg::ALU_ADD, alu_control);
        check_bit("alu_src", 1'b0, alu_src);
        check_imm("imm_src", control_pkg::IMM_I, imm_src);
        check_bit("reg_write", 1'b0, reg_write);
        check_store("ctrl_data_mem", control_pkg::ST_WORD, ctrl_data_mem);
        check_load("ctrl_sign_ext_data", control_pkg::LD_WORD, ctrl_sign_ext_data);
    endtask

    // expected columns 5 to 13
    task automatic check_line(input int j);
        ctx = $sformatf("vector %0d", j);
        check_bit("pc_src", tbl[j][5][0], pc_src);
        check_result("result_src", control_pkg::result_src_e'(tbl[j][6][2:0]), result_src);
        check_bit("mem_write", tbl[j][7][0], mem_write);
        check_alu("alu_control", control_pkg::alu_op_e'(tbl[j][8][3:0]), alu_control);
        check_bit("alu_src", tbl[j][9][0], alu_src);
        check_imm("imm_src", control_pkg::imm_src_e'(tbl[j][10][2:0]), imm_src);
        check_bit("reg_write", tbl[j][11][0], reg_write);
        check_store("ctrl_data_mem", control_pkg::store_size_e'(tbl[j][12][1:0]),
                    ctrl_data_mem);
        check_load("ctrl_sign_ext_data", control_pkg::load_ext_e'(tbl[j][13][2:0]),
                   ctrl_sign_ext_data);
    endtask

    task automatic read_vectors();
        int    fd;
        int    cnt;
        string line;
        fd = $fopen("dv/control_unit_input.txt", "r");
        if (fd == 0)
        begin
            $display("could not open the data file dv/control_unit_input.txt");
            errors++;
            return;
        end
        while ($fgets(line, fd) != 0)
        begin
            // comments and blank lines
            if (line.len() < 2 || line.substr(0, 1) == "//")
                continue;
            if (n_vec == 256)
            begin
                $display("the data file holds more than 256 vectors");
                errors++;
                break;
            end
            cnt = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                          tbl[n_vec][0], tbl[n_vec][1], tbl[n_vec][2], tbl[n_vec][3],
                          tbl[n_vec][4], tbl[n_vec][5], tbl[n_vec][6], tbl[n_vec][7],
                          tbl[n_vec][8], tbl[n_vec][9], tbl[n_vec][10], tbl[n_vec][11],
                          tbl[n_vec][12], tbl[n_vec][13]);
            if (cnt == 14)
                n_vec++;
            else
            begin
                $display("a data file line could not be parsed: %s", line);
                errors++;
            end
        end
        $fclose(fd);
    endtask

    task automatic drive_instr(input int j);
        op     <= control_pkg::opcode_e'(tbl[j][0][6:0]);
        funct3 <= tbl[j][1][2:0];
        funct7 <= tbl[j][2][6:0];
    endtask

    initial
    begin
        clk          = 1'b0;
        rst          = 1'b1;
        op           = control_pkg::opcode_e'(7'h00);
        funct3       = '0;
        funct7       = '0;
        zero         = 1'b0;
        conditional  = 1'b0;
        n_vec        = 0;
        checks       = 0;
        errors       = 0;
        assert_fails = 0;
        cycles       = 0;
        max_cycles   = 0;
        read_vectors();
        // vectors plus reset plus slack
        max_cycles = n_vec + 10 + 20;

        // 10 rising edges under reset
        @(posedge clk);
        @(negedge clk);
        ctx = "during reset";
        check_inactive();
        repeat (9) @(posedge clk);
        rst <= 1'b0;

        // instruction of vector i goes in with the flags of vector i-1
        for (vec_idx = 0; vec_idx <= n_vec; vec_idx++)
        begin
            if (vec_idx < n_vec)
                drive_instr(vec_idx);
            else
            begin
                // trailing bubble of an illegal opcode
                op     <= control_pkg::opcode_e'(7'h00);
                funct3 <= '0;
                funct7 <= '0;
            end
            if (vec_idx > 0)
            begin
                zero        <= tbl[vec_idx-1][3][0];
                conditional <= tbl[vec_idx-1][4][0];
            end
            else
            begin
                // flags high while the reset word must still give pc_src 0
                zero        <= 1'b1;
                conditional <= 1'b1;
            end
            @(negedge clk);
            if (vec_idx == 0)
            begin
                ctx = "after reset";
                check_inactive();
            end
            else
                check_line(vec_idx - 1);
            @(posedge clk);
        end

        // assertion results of the last edge
        @(negedge clk);
        assert_fails = DUT.u_ex_control_stage.u_control_unit_assertions.fail_count;
        $display("checks: %0d, errors: %0d, assertion failures: %0d", checks, errors,
                 assert_fails);
        if (errors == 0 && assert_fails == 0)
            $display("Verification passed");
        else
            $display("Verification failed");
        $finish;
    end

endmodule

// File: source/alu_decoder.sv
module alu_decoder (
    input  control_pkg::opcode_e            op,
    input  logic [control_pkg::F3_W-1:0]    funct3,
    input  logic [control_pkg::F7_W-1:0]    funct7,
    output control_pkg::alu_op_e            alu_control
);

    logic alt;

    // sub / sra / srai select
    assign alt = funct7[control_pkg::F7_ALT_BIT];

    always_comb
    begin
        // loads, stores, jumps and upper immediates all add
        alu_control = control_pkg::ALU_ADD;

        case (op)
            control_pkg::OP_IMM, control_pkg::OP_REG:
            begin
                case (funct3)
                    3'b000:
                    begin
                        // addi never subtracts, funct7 there is immediate
                        if (op == control_pkg::OP_REG && alt)
                            alu_control = control_pkg::ALU_SUB;
                        else
                            alu_control = control_pkg::ALU_ADD;
                    end
                    3'b001: alu_control = control_pkg::ALU_SLL;
                    3'b010: alu_control = control_pkg::ALU_SLT;
                    3'b011: alu_control = control_pkg::ALU_SLTU;
                    3'b100: alu_control = control_pkg::ALU_XOR;
                    3'b101:
                    begin
                        // srl/sra and srli/srai
                        if (alt)
                            alu_control = control_pkg::ALU_SRA;
                        else
                            alu_control = control_pkg::ALU_SRL;
                    end
                    3'b110: alu_control = control_pkg::ALU_OR;
                    default: alu_control = control_pkg::ALU_AND;
                endcase
            end
            control_pkg::OP_BRANCH:
            begin
                case (funct3)
                    // beq bne compare via zero flag
                    3'b000, 3'b001: alu_control = control_pkg::ALU_SUB;
                    // blt bge
                    3'b100, 3'b101: alu_control = control_pkg::ALU_SLT;
                    // bltu bgeu
                    3'b110, 3'b111: alu_control = control_pkg::ALU_SLTU;
                    default:        alu_control = control_pkg::ALU_ADD;
                endcase
            end
            default:
                alu_control = control_pkg::ALU_ADD;
        endcase
    end

endmodule

// File: source/control_pkg.sv
package control_pkg;

    // instruction field widths
    localparam int OP_W = 7;
    localparam int F3_W = 3;
    localparam int F7_W = 7;

    // funct7 bit that picks sub, sra and srai
    localparam int F7_ALT_BIT = 5;

    // major opcodes handled by the decoder
    typedef enum logic [OP_W-1:0] {
        OP_LOAD   = 7'b0000011,
        OP_IMM    = 7'b0010011,
        OP_AUIPC  = 7'b0010111,
        OP_STORE  = 7'b0100011,
        OP_REG    = 7'b0110011,
        OP_LUI    = 7'b0110111,
        OP_BRANCH = 7'b1100011,
        OP_JALR   = 7'b1100111,
        OP_JAL    = 7'b1101111
    } opcode_e;

    // alu operation codes
    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_OR   = 4'd2,
        ALU_AND  = 4'd3,
        ALU_XOR  = 4'd4,
        ALU_SLL  = 4'd5,
        ALU_SRL  = 4'd6,
        ALU_SRA  = 4'd7,
        ALU_SLT  = 4'd8,
        ALU_SLTU = 4'd9
    } alu_op_e;

    // write-back source for the register file
    typedef enum logic [2:0] {
        RES_ALU    = 3'd0,
        RES_MEM    = 3'd1,
        RES_PC4    = 3'd2,
        RES_IMM    = 3'd3,
        RES_PC_IMM = 3'd4
    } result_src_e;

    // immediate format
    typedef enum logic [2:0] {
        IMM_I = 3'd0,
        IMM_S = 3'd1,
        IMM_B = 3'd2,
        IMM_J = 3'd3,
        IMM_U = 3'd4
    } imm_src_e;

    // store width to data memory
    typedef enum logic [1:0] {
        ST_WORD = 2'd0,
        ST_HALF = 2'd1,
        ST_BYTE = 2'd2
    } store_size_e;

    // load width and extension
    typedef enum logic [2:0] {
        LD_WORD   = 3'd0,
        LD_HALF   = 3'd1,
        LD_BYTE   = 3'd2,
        LD_BYTE_U = 3'd3,
        LD_HALF_U = 3'd4
    } load_ext_e;

    // branch kind, lt/ge shared by signed and unsigned forms
    typedef enum logic [2:0] {
        BR_NONE = 3'd0,
        BR_EQ   = 3'd1,
        BR_NE   = 3'd2,
        BR_LT   = 3'd3,
        BR_GE   = 3'd4
    } branch_cond_e;

endpackage

// File: source/control_unit.sv
module control_unit (
    input  logic                            clk,
    input  logic                            rst,
    input  control_pkg::opcode_e            op,
    input  logic [control_pkg::F3_W-1:0]    funct3,
    input  logic [control_pkg::F7_W-1:0]    funct7,
    input  logic                            zero,
    input  logic                            conditional,
    output logic                            pc_src,
    output control_pkg::result_src_e        result_src,
    output logic                            mem_write,
    output control_pkg::alu_op_e            alu_control,
    output logic                            alu_src,
    output control_pkg::imm_src_e           imm_src,
    output logic                            reg_write,
    output control_pkg::store_size_e        ctrl_data_mem,
    output control_pkg::load_ext_e          ctrl_sign_ext_data
);

    // decode-side controls, before the pipeline register
    logic                      reg_write_d;
    logic                      mem_write_d;
    logic                      alu_src_d;
    logic                      jump_d;
    control_pkg::result_src_e  result_src_d;
    control_pkg::imm_src_e     imm_src_d;
    control_pkg::store_size_e  ctrl_data_mem_d;
    control_pkg::load_ext_e    ctrl_sign_ext_data_d;
    control_pkg::branch_cond_e branch_cond_d;
    control_pkg::alu_op_e      alu_control_d;

    main_decoder u_main_decoder (
        .op                 (op),
        .funct3             (funct3),
        .reg_write          (reg_write_d),
        .mem_write          (mem_write_d),
        .alu_src            (alu_src_d),
        .jump               (jump_d),
        .result_src         (result_src_d),
        .imm_src            (imm_src_d),
        .ctrl_data_mem      (ctrl_data_mem_d),
        .ctrl_sign_ext_data (ctrl_sign_ext_data_d),
        .branch_cond        (branch_cond_d)
    );

    alu_decoder u_alu_decoder (
        .op          (op),
        .funct3      (funct3),
        .funct7      (funct7),
        .alu_control (alu_control_d)
    );

    // registered controls and pc select for execute
    ex_control_stage u_ex_control_stage (
        .clk                  (clk),
        .rst                  (rst),
        .zero                 (zero),
        .conditional          (conditional),
        .reg_write_d          (reg_write_d),
        .mem_write_d          (mem_write_d),
        .alu_src_d            (alu_src_d),
        .jump_d               (jump_d),
        .result_src_d         (result_src_d),
        .imm_src_d            (imm_src_d),
        .ctrl_data_mem_d      (ctrl_data_mem_d),
        .ctrl_sign_ext_data_d (ctrl_sign_ext_data_d),
        .branch_cond_d        (branch_cond_d),
        .alu_control_d        (alu_control_d),
        .reg_write            (reg_write),
        .mem_write            (mem_write),
        .alu_src              (alu_src),
        .result_src           (result_src),
        .imm_src              (imm_src),
        .ctrl_data_mem        (ctrl_data_mem),
        .ctrl_sign_ext_data   (ctrl_sign_ext_data),
        .alu_control          (alu_control),
        .pc_src               (pc_src)
    );

endmodule

// File: source/ex_control_stage.sv
module ex_control_stage (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            zero,
    input  logic                            conditional,
    input  logic                            reg_write_d,
    input  logic                            mem_write_d,
    input  logic                            alu_src_d,
    input  logic                            jump_d,
    input  control_pkg::result_src_e        result_src_d,
    input  control_pkg::imm_src_e           imm_src_d,
    input  control_pkg::store_size_e        ctrl_data_mem_d,
    input  control_pkg::load_ext_e          ctrl_sign_ext_data_d,
    input  control_pkg::branch_cond_e       branch_cond_d,
    input  control_pkg::alu_op_e            alu_control_d,
    output logic                            reg_write,
    output logic                            mem_write,
    output logic                            alu_src,
    output control_pkg::result_src_e        result_src,
    output control_pkg::imm_src_e           imm_src,
    output control_pkg::store_size_e        ctrl_data_mem,
    output control_pkg::load_ext_e          ctrl_sign_ext_data,
    output control_pkg::alu_op_e            alu_control,
    output logic                            pc_src
);

    // branch kind and jump only feed the next-pc select
    control_pkg::branch_cond_e branch_cond;
    logic                      jump;

    // decode to execute pipeline register
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            reg_write          <= 1'b0;
            mem_write          <= 1'b0;
            alu_src            <= 1'b0;
            jump               <= 1'b0;
            result_src         <= control_pkg::RES_ALU;
            imm_src            <= control_pkg::IMM_I;
            ctrl_data_mem      <= control_pkg::ST_WORD;
            ctrl_sign_ext_data <= control_pkg::LD_WORD;
            branch_cond        <= control_pkg::BR_NONE;
            alu_control        <= control_pkg::ALU_ADD;
        end
        else
        begin
            // no stall, new word every cycle
            reg_write          <= reg_write_d;
            mem_write          <= mem_write_d;
            alu_src            <= alu_src_d;
            jump               <= jump_d;
            result_src         <= result_src_d;
            imm_src            <= imm_src_d;
            ctrl_data_mem      <= ctrl_data_mem_d;
            ctrl_sign_ext_data <= ctrl_sign_ext_data_d;
            branch_cond        <= branch_cond_d;
            alu_control        <= alu_control_d;
        end
    end

    // next-pc select, flags come live from the alu this cycle
    always_comb
    begin
        if (jump)
            pc_src = 1'b1;
        else
        begin
            case (branch_cond)
                control_pkg::BR_EQ: pc_src = zero;
                control_pkg::BR_NE: pc_src = ~zero;
                // signed or unsigned chosen by the alu op
                control_pkg::BR_LT: pc_src = conditional;
                control_pkg::BR_GE: pc_src = ~conditional;
                default:            pc_src = 1'b0;
            endcase
        end
    end

endmodule

// File: source/main_decoder.sv
module main_decoder (
    input  control_pkg::opcode_e            op,
    input  logic [control_pkg::F3_W-1:0]    funct3,
    output logic                            reg_write,
    output logic                            mem_write,
    output logic                            alu_src,
    output logic                            jump,
    output control_pkg::result_src_e        result_src,
    output control_pkg::imm_src_e           imm_src,
    output control_pkg::store_size_e        ctrl_data_mem,
    output control_pkg::load_ext_e          ctrl_sign_ext_data,
    output control_pkg::branch_cond_e       branch_cond
);

    always_comb
    begin
        // inactive word unless a legal encoding below says otherwise
        reg_write          = 1'b0;
        mem_write          = 1'b0;
        alu_src            = 1'b0;
        jump               = 1'b0;
        result_src         = control_pkg::RES_ALU;
        imm_src            = control_pkg::IMM_I;
        ctrl_data_mem      = control_pkg::ST_WORD;
        ctrl_sign_ext_data = control_pkg::LD_WORD;
        branch_cond        = control_pkg::BR_NONE;

        case (op)
            control_pkg::OP_LOAD:
            begin
                // lb lh lw lbu lhu only
                if (funct3 inside {3'b000, 3'b001, 3'b010, 3'b100, 3'b101})
                begin
                    result_src = control_pkg::RES_MEM;
                    alu_src    = 1'b1;
                    reg_write  = 1'b1;
                end
                case (funct3)
                    3'b000:  ctrl_sign_ext_data = control_pkg::LD_BYTE;
                    3'b001:  ctrl_sign_ext_data = control_pkg::LD_HALF;
                    3'b100:  ctrl_sign_ext_data = control_pkg::LD_BYTE_U;
                    3'b101:  ctrl_sign_ext_data = control_pkg::LD_HALF_U;
                    // lw and illegal codes
                    default: ctrl_sign_ext_data = control_pkg::LD_WORD;
                endcase
            end
            control_pkg::OP_STORE:
            begin
                // sb sh sw only
                if (funct3 inside {3'b000, 3'b001, 3'b010})
                begin
                    mem_write = 1'b1;
                    alu_src   = 1'b1;
                    imm_src   = control_pkg::IMM_S;
                end
                case (funct3)
                    3'b000:  ctrl_data_mem = control_pkg::ST_BYTE;
                    3'b001:  ctrl_data_mem = control_pkg::ST_HALF;
                    default: ctrl_data_mem = control_pkg::ST_WORD;
                endcase
            end
            control_pkg::OP_BRANCH:
            begin
                case (funct3)
                    3'b000:         branch_cond = control_pkg::BR_EQ;
                    3'b001:         branch_cond = control_pkg::BR_NE;
                    // blt and bltu
                    3'b100, 3'b110: branch_cond = control_pkg::BR_LT;
                    // bge and bgeu
                    3'b101, 3'b111: branch_cond = control_pkg::BR_GE;
                    default:        branch_cond = control_pkg::BR_NONE;
                endcase
                // funct3 2 and 3 stay fully inactive
                if (branch_cond != control_pkg::BR_NONE)
                    imm_src = control_pkg::IMM_B;
            end
            control_pkg::OP_IMM:
            begin
                // every funct3 is a valid immediate op
                alu_src   = 1'b1;
                reg_write = 1'b1;
            end
            control_pkg::OP_REG:
                reg_write = 1'b1;
            control_pkg::OP_LUI:
            begin
                // immediate goes straight to rd
                imm_src    = control_pkg::IMM_U;
                result_src = control_pkg::RES_IMM;
                reg_write  = 1'b1;
            end
            control_pkg::OP_AUIPC:
            begin
                imm_src    = control_pkg::IMM_U;
                result_src = control_pkg::RES_PC_IMM;
                alu_src    = 1'b1;
                reg_write  = 1'b1;
            end
            control_pkg::OP_JAL:
            begin
                // link pc+4, target from j immediate
                imm_src    = control_pkg::IMM_J;
                result_src = control_pkg::RES_PC4;
                reg_write  = 1'b1;
                jump       = 1'b1;
            end
            control_pkg::OP_JALR:
            begin
                result_src = control_pkg::RES_PC4;
                reg_write  = 1'b1;
                jump       = 1'b1;
            end
            default:
                jump = 1'b0;
        endcase
    end

endmodule
